//--- src/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Address and PC width of the core
`define FETCH_XLEN 32

// Number of direct-mapped branch target buffer entries
`define FETCH_BTB_ENTRIES 16

// Depth of the return address stack and a power of two so the pointer wraps
`define FETCH_RAS_DEPTH 4

// Instruction memory depth in 32-bit words
`define FETCH_IMEM_WORDS 256

// Address of the first instruction fetched after reset
`define FETCH_RESET_PC 32'h00000000

// Fetch mode where 0 fetches on the current PC and 1 fetches on the next PC
`define FETCH_BPRED 0

`endif

//--- src/fetch_pkg.sv
`include "fetch_settings.svh"

package fetch_pkg;

  // Result of one BTB lookup for the address being fetched
  typedef struct packed {
    logic                   hit;
    logic                   taken;
    logic                   is_return;
    logic [`FETCH_XLEN-1:0] target;
  } btb_pred_t;

  // Top of the return address stack
  typedef struct packed {
    logic                   valid;
    logic [`FETCH_XLEN-1:0] target;
  } ras_pred_t;

  // Redirect from branch resolution in execute
  typedef struct packed {
    logic                   valid;
    logic [`FETCH_XLEN-1:0] target;
  } redirect_t;

  // Training write for one BTB entry
  typedef struct packed {
    logic                   valid;
    logic [`FETCH_XLEN-1:0] pc;
    logic [`FETCH_XLEN-1:0] target;
    logic                   taken;
    logic                   is_return;
  } btb_update_t;

  // Everything decode receives for one fetched instruction
  typedef struct packed {
    logic                   valid;
    logic [`FETCH_XLEN-1:0] pc;
    logic [`FETCH_XLEN-1:0] pc_plus4;
    logic [31:0]            instr;
    btb_pred_t              btb;
    ras_pred_t              ras;
  } fetch_bundle_t;

  // Where the next PC comes from, listed in priority order
  typedef enum logic [2:0] {
    src_redirect,
    src_hold,
    src_return,
    src_taken,
    src_sequential
  } next_pc_src_e;

  // The canonical RV32I NOP encoding
  localparam logic [31:0] instr_nop = 32'h00000013;

endpackage

//--- src/pc_gen.sv
`timescale 1ns/100ps
`include "fetch_settings.svh"

module pc_gen (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stall,
  input  fetch_pkg::redirect_t   redirect,
  input  fetch_pkg::btb_pred_t   btb_pred,
  input  fetch_pkg::ras_pred_t   ras_pred,
  output logic [`FETCH_XLEN-1:0] pc,
  output logic [`FETCH_XLEN-1:0] pc_next,
  output logic                   ras_pop
);
  import fetch_pkg::*;

  localparam logic [`FETCH_XLEN-1:0] word_bytes = `FETCH_XLEN'(4);

  next_pc_src_e src;
  logic         predict_taken;
  logic         predict_return;

  // A taken BTB hit redirects fetch to the stored target
  assign predict_taken  = btb_pred.hit && btb_pred.taken;
  // A return only follows the stack when the stack has an entry
  assign predict_return = predict_taken && btb_pred.is_return && ras_pred.valid;

  // Priority choice of the next PC source
  always_comb begin
    if (redirect.valid) begin
      src = src_redirect;
    end else if (stall) begin
      src = src_hold;
    end else if (predict_return) begin
      src = src_return;
    end else if (predict_taken) begin
      src = src_taken;
    end else begin
      src = src_sequential;
    end
  end

  always_comb begin
    case (src)
      src_redirect: pc_next = redirect.target;
      src_hold:     pc_next = pc;
      src_return:   pc_next = ras_pred.target;
      src_taken:    pc_next = btb_pred.target;
      default:      pc_next = pc + word_bytes;
    endcase
  end

  // The stack is consumed only when the return path is really taken
  assign ras_pop = (src == src_return);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `FETCH_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // Exactly one source drives the next PC in every cycle
  a_one_source: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot({src == src_redirect, src == src_hold, src == src_return,
             src == src_taken, src == src_sequential}))
    else $error("pc_gen selected no single next PC source");

endmodule

//--- src/branch_target_buffer.sv
`timescale 1ns/100ps
`include "fetch_settings.svh"

module branch_target_buffer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`FETCH_XLEN-1:0] lookup_pc,
  output fetch_pkg::btb_pred_t   pred,
  input  fetch_pkg::btb_update_t update
);

  localparam int idx_w = $clog2(`FETCH_BTB_ENTRIES);
  localparam int tag_w = `FETCH_XLEN - idx_w - 2;

  // Per-entry state with the valid bits kept apart so they can be cleared
  logic [`FETCH_BTB_ENTRIES-1:0] valid_q;
  logic [tag_w-1:0]              tag_mem    [`FETCH_BTB_ENTRIES];
  logic [`FETCH_XLEN-1:0]        target_mem [`FETCH_BTB_ENTRIES];
  logic [`FETCH_BTB_ENTRIES-1:0] taken_mem;
  logic [`FETCH_BTB_ENTRIES-1:0] return_mem;

  logic [idx_w-1:0] rd_idx;
  logic [tag_w-1:0] rd_tag;
  logic [idx_w-1:0] wr_idx;
  logic [tag_w-1:0] wr_tag;
  logic             hit;

  // Word bits index the table and the upper bits form the tag
  assign rd_idx = lookup_pc[idx_w+1:2];
  assign rd_tag = lookup_pc[`FETCH_XLEN-1:idx_w+2];
  assign wr_idx = update.pc[idx_w+1:2];
  assign wr_tag = update.pc[`FETCH_XLEN-1:idx_w+2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (update.valid) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // A training write replaces the whole entry at its index
  always_ff @(posedge clk) begin
    if (update.valid) begin
      tag_mem[wr_idx]    <= wr_tag;
      target_mem[wr_idx] <= update.target;
      taken_mem[wr_idx]  <= update.taken;
      return_mem[wr_idx] <= update.is_return;
    end
  end

  assign hit = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);

  // Flags are qualified by the hit so a miss never predicts anything
  always_comb begin
    pred.hit       = hit;
    pred.taken     = hit && taken_mem[rd_idx];
    pred.is_return = hit && return_mem[rd_idx];
    pred.target    = target_mem[rd_idx];
  end

endmodule

//--- src/return_address_stack.sv
`timescale 1ns/100ps
`include "fetch_settings.svh"

module return_address_stack (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push,
  input  logic [`FETCH_XLEN-1:0] push_addr,
  input  logic                   pop,
  output fetch_pkg::ras_pred_t   pred
);

  localparam int              ptr_w    = $clog2(`FETCH_RAS_DEPTH);
  localparam int              cnt_w    = $clog2(`FETCH_RAS_DEPTH + 1);
  localparam logic [cnt_w-1:0] full_cnt = cnt_w'(`FETCH_RAS_DEPTH);

  logic [`FETCH_XLEN-1:0] stack_mem [`FETCH_RAS_DEPTH];
  logic [ptr_w-1:0]       top_q;
  logic [ptr_w-1:0]       push_slot;
  logic [cnt_w-1:0]       count_q;

  // Push and pop together overwrite the current top in place
  assign push_slot = pop ? top_q : top_q + ptr_w'(1);

  // The pointer wraps so an overflow silently replaces the oldest entry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      top_q   <= '0;
      count_q <= '0;
    end else begin
      case ({push, pop})
        2'b10: begin
          top_q <= top_q + ptr_w'(1);
          if (count_q != full_cnt) begin
            count_q <= count_q + cnt_w'(1);
          end
        end
        2'b01: begin
          top_q <= top_q - ptr_w'(1);
          if (count_q != '0) begin
            count_q <= count_q - cnt_w'(1);
          end
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      stack_mem[push_slot] <= push_addr;
    end
  end

  assign pred.valid  = (count_q != '0);
  assign pred.target = stack_mem[top_q];

  // The PC generator only pops on a valid prediction
  a_no_empty_pop: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> (count_q != '0))
    else $error("return address stack popped while empty");

endmodule

//--- src/imem_bram.sv
`timescale 1ns/100ps
`include "fetch_settings.svh"

module imem_bram (
  input  logic                   clk,
  input  logic                   ren,
  input  logic [`FETCH_XLEN-1:0] raddr,
  output logic [31:0]            rdata,
  input  logic                   wen,
  input  logic [`FETCH_XLEN-1:0] waddr,
  input  logic [31:0]            wdata
);

  localparam int addr_w = $clog2(`FETCH_IMEM_WORDS);

  logic [31:0]       mem [`FETCH_IMEM_WORDS];
  logic [addr_w-1:0] ridx;
  logic [addr_w-1:0] widx;

  // Byte addresses are turned into word indices
  assign ridx = raddr[addr_w+1:2];
  assign widx = waddr[addr_w+1:2];

  // Load port used to fill the program
  always_ff @(posedge clk) begin
    if (wen) begin
      mem[widx] <= wdata;
    end
  end

  // Registered read so the word shows up one cycle after its address
  // and holds while the read is disabled
  always_ff @(posedge clk) begin
    if (ren) begin
      rdata <= mem[ridx];
    end
  end

endmodule

//--- src/fetch_stage_bram.sv
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_stage_bram #(
  parameter int BPRED = `FETCH_BPRED
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`FETCH_XLEN-1:0]   pc,
  input  logic [`FETCH_XLEN-1:0]   pc_next,
  input  logic                     pc_stall,
  input  logic                     if_id_stall,
  input  logic                     if_id_flush,
  input  fetch_pkg::btb_pred_t     btb_pred,
  input  fetch_pkg::ras_pred_t     ras_pred,
  output logic                     imem_ren,
  output logic [`FETCH_XLEN-1:0]   imem_raddr,
  input  logic [31:0]              imem_rdata,
  output fetch_pkg::fetch_bundle_t bundle
);
  import fetch_pkg::*;

  localparam logic [`FETCH_XLEN-1:0] word_bytes = `FETCH_XLEN'(4);

  // Stage 1 lines up with the BRAM output and stage 2 with the instruction register
  logic [`FETCH_XLEN-1:0] pc_s1;
  logic [`FETCH_XLEN-1:0] pc_s2;
  logic [`FETCH_XLEN-1:0] pc_plus4_s2;
  btb_pred_t              btb_s2_in;
  btb_pred_t              btb_s2;
  ras_pred_t              ras_s2_in;
  ras_pred_t              ras_s2;
  logic [31:0]            instr_s2;
  logic                   flush_extend;
  logic                   started;
  logic                   valid_s2;

  // The read stays enabled through reset so the first word is ready early
  assign imem_ren = !rst_n || !pc_stall;

  if (BPRED != 0) begin : g_early_fetch
    // Fetch runs one PC ahead so the lookup on pc already describes the word
    // that left the BRAM one cycle later
    assign imem_raddr = pc_next;
    assign btb_s2_in  = btb_pred;
    assign ras_s2_in  = ras_pred;

    // The redirect target is fetched in the redirect cycle itself
    assign flush_extend = 1'b0;
  end else begin : g_pc_fetch
    btb_pred_t btb_s1;
    ras_pred_t ras_s1;

    assign imem_raddr = pc;

    // Predictions belong to the current PC and follow it through stage 1
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        btb_s1 <= '0;
        ras_s1 <= '0;
      end else if (!if_id_stall) begin
        btb_s1 <= btb_pred;
        ras_s1 <= ras_pred;
      end
    end

    assign btb_s2_in = btb_s1;
    assign ras_s2_in = ras_s1;

    // The old-path word fetched during the redirect cycle sits in stage 1
    // and must be killed when it moves on, even after a stall
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        flush_extend <= 1'b0;
      end else if (if_id_flush) begin
        flush_extend <= 1'b1;
      end else if (!if_id_stall) begin
        flush_extend <= 1'b0;
      end
    end
  end

  // PC pipeline keeps moving through flushes and only the slot validity drops
  always_ff @(posedge clk) begin
    if (!if_id_stall) begin
      pc_s1       <= imem_raddr;
      pc_s2       <= pc_s1;
      pc_plus4_s2 <= pc_s1 + word_bytes;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      btb_s2 <= '0;
      ras_s2 <= '0;
    end else if (!if_id_stall) begin
      btb_s2 <= btb_s2_in;
      ras_s2 <= ras_s2_in;
    end
  end

  // Flushed or reset slots carry a NOP into decode
  always_ff @(posedge clk) begin
    if (!rst_n || if_id_flush || flush_extend) begin
      instr_s2 <= instr_nop;
    end else if (!if_id_stall) begin
      instr_s2 <= imem_rdata;
    end
  end

  // The first slot after reset holds no fetched word yet
  // so started delays validity by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      started  <= 1'b0;
      valid_s2 <= 1'b0;
    end else begin
      if (!if_id_stall) begin
        started <= 1'b1;
      end
      if (if_id_flush || flush_extend) begin
        valid_s2 <= 1'b0;
      end else if (!if_id_stall) begin
        valid_s2 <= started;
      end
    end
  end

  always_comb begin
    bundle.valid    = valid_s2;
    bundle.pc       = pc_s2;
    bundle.pc_plus4 = pc_plus4_s2;
    bundle.instr    = instr_s2;
    bundle.btb      = btb_s2;
    bundle.ras      = ras_s2;
  end

  // Nothing from the squashed path reaches decode right after a redirect
  a_flush_invalidates: assert property (@(posedge clk) disable iff (!rst_n)
    if_id_flush |=> !bundle.valid)
    else $error("fetch bundle valid on the cycle after a flush");

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_unit (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     id_stall,
  input  fetch_pkg::redirect_t     redirect,
  input  fetch_pkg::btb_update_t   btb_update,
  input  logic                     ras_push,
  input  logic [`FETCH_XLEN-1:0]   ras_push_addr,
  input  logic                     load_en,
  input  logic [`FETCH_XLEN-1:0]   load_addr,
  input  logic [31:0]              load_data,
  output fetch_pkg::fetch_bundle_t id_bundle
);
  import fetch_pkg::*;

  logic [`FETCH_XLEN-1:0] pc;
  logic [`FETCH_XLEN-1:0] pc_next;
  logic                   ras_pop;
  btb_pred_t              btb_pred;
  ras_pred_t              ras_pred;
  logic                   imem_ren;
  logic [`FETCH_XLEN-1:0] imem_raddr;
  logic [31:0]            imem_rdata;

  // Decode back-pressure stalls both the PC and the IF/ID slot
  pc_gen i_pc_gen (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (id_stall),
    .redirect (redirect),
    .btb_pred (btb_pred),
    .ras_pred (ras_pred),
    .pc       (pc),
    .pc_next  (pc_next),
    .ras_pop  (ras_pop)
  );

  // Looked up on the current PC in the same cycle
  branch_target_buffer i_btb (
    .clk       (clk),
    .rst_n     (rst_n),
    .lookup_pc (pc),
    .pred      (btb_pred),
    .update    (btb_update)
  );

  return_address_stack i_ras (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (ras_push),
    .push_addr (ras_push_addr),
    .pop       (ras_pop),
    .pred      (ras_pred)
  );

  imem_bram i_imem (
    .clk   (clk),
    .ren   (imem_ren),
    .raddr (imem_raddr),
    .rdata (imem_rdata),
    .wen   (load_en),
    .waddr (load_addr),
    .wdata (load_data)
  );

  // A resolved redirect is the flush of the fetch slots
  fetch_stage_bram #(
    .BPRED (`FETCH_BPRED)
  ) i_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .pc          (pc),
    .pc_next     (pc_next),
    .pc_stall    (id_stall),
    .if_id_stall (id_stall),
    .if_id_flush (redirect.valid),
    .btb_pred    (btb_pred),
    .ras_pred    (ras_pred),
    .imem_ren    (imem_ren),
    .imem_raddr  (imem_raddr),
    .imem_rdata  (imem_rdata),
    .bundle      (id_bundle)
  );

endmodule

//--- dv/fetch_checker.sv
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_checker #(
  parameter logic [31:0] prog_pattern = 32'h00000000
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     id_stall,
  input  fetch_pkg::redirect_t     redirect,
  input  fetch_pkg::btb_update_t   btb_update,
  input  logic                     ras_push,
  input  logic [`FETCH_XLEN-1:0]   ras_push_addr,
  input  fetch_pkg::fetch_bundle_t id_bundle,
  output int                       n_bundles,
  output int                       n_pc_err,
  output int                       n_data_err,
  output int                       n_pred_err,
  output int                       n_hold_err,
  output int                       n_valid_err
);
  import fetch_pkg::*;

  // Reference state: the PC decode should see next, a direct-mapped table and a stack
  logic [31:0]   exp_pc;
  logic          btb_v       [`FETCH_BTB_ENTRIES];
  logic [31:0]   btb_pc_tab  [`FETCH_BTB_ENTRIES];
  logic [31:0]   btb_tgt_tab [`FETCH_BTB_ENTRIES];
  logic          btb_tk_tab  [`FETCH_BTB_ENTRIES];
  logic          btb_ret_tab [`FETCH_BTB_ENTRIES];
  logic [31:0]   ras_q       [$];
  fetch_bundle_t prev_bundle;
  logic          prev_stall;
  logic          prev_flush;
  int            cycle;

  // Each loaded word is its own byte address mixed with the pattern
  function automatic logic [31:0] program_word(input logic [31:0] addr);
    return addr ^ prog_pattern;
  endfunction

  // Word bits of the PC pick the table slot
  function automatic int btb_slot(input logic [31:0] addr);
    return int'((addr >> 2) % `FETCH_BTB_ENTRIES);
  endfunction

  task automatic report_mismatch(input string msg);
    $display("ERROR @%0t: %s", $time, msg);
  endtask

  task automatic reset_model();
    exp_pc = `FETCH_RESET_PC;
    for (int i = 0; i < `FETCH_BTB_ENTRIES; i++) begin
      btb_v[i] = 1'b0;
    end
    ras_q.delete();
    cycle      = 0;
    prev_stall = 1'b0;
    prev_flush = 1'b0;
  endtask

  // Compare one accepted bundle with the model and advance the expected PC
  task automatic check_bundle();
    int   slot;
    logic hit;
    logic taken;
    logic ret;
    logic ras_ok;
    slot  = btb_slot(exp_pc);
    hit   = btb_v[slot] && (btb_pc_tab[slot] == exp_pc);
    taken = hit && btb_tk_tab[slot];
    ret   = hit && btb_ret_tab[slot];
    n_bundles++;
    if (id_bundle.pc != exp_pc) begin
      n_pc_err++;
      report_mismatch($sformatf("bundle pc %h, expected %h", id_bundle.pc, exp_pc));
    end
    if (id_bundle.pc_plus4 != exp_pc + 32'd4) begin
      n_data_err++;
      report_mismatch($sformatf("pc_plus4 %h for pc %h", id_bundle.pc_plus4, exp_pc));
    end
    if (id_bundle.instr == instr_nop) begin
      n_data_err++;
      report_mismatch($sformatf("NOP in a valid slot at pc %h", exp_pc));
    end else if (id_bundle.instr != program_word(exp_pc)) begin
      n_data_err++;
      report_mismatch($sformatf("instr %h at pc %h, expected %h", id_bundle.instr, exp_pc,
                                program_word(exp_pc)));
    end
    if (id_bundle.btb.hit != hit || id_bundle.btb.taken != taken ||
        id_bundle.btb.is_return != ret ||
        (hit && id_bundle.btb.target != btb_tgt_tab[slot])) begin
      n_pred_err++;
      report_mismatch($sformatf("BTB fields at pc %h, expected hit %b taken %b return %b",
                                exp_pc, hit, taken, ret));
    end
    // The stack seen at lookup time is the one before this bundle's own pop
    ras_ok = (id_bundle.ras.valid == (ras_q.size() > 0));
    if (ras_q.size() > 0 && id_bundle.ras.target != ras_q[$]) begin
      ras_ok = 1'b0;
    end
    if (!ras_ok) begin
      n_pred_err++;
      report_mismatch($sformatf("RAS fields at pc %h, stack holds %0d", exp_pc, ras_q.size()));
    end
    // Return before taken before sequential
    if (taken && ret && ras_q.size() > 0) begin
      exp_pc = ras_q.pop_back();
    end else if (taken) begin
      exp_pc = btb_tgt_tab[slot];
    end else begin
      exp_pc = exp_pc + 32'd4;
    end
  endtask

  // Resolution inputs act after the bundle of the same cycle was taken
  task automatic take_inputs();
    int slot;
    if (redirect.valid) begin
      exp_pc = redirect.target;
    end
    if (btb_update.valid) begin
      slot              = btb_slot(btb_update.pc);
      btb_v[slot]       = 1'b1;
      btb_pc_tab[slot]  = btb_update.pc;
      btb_tgt_tab[slot] = btb_update.target;
      btb_tk_tab[slot]  = btb_update.taken;
      btb_ret_tab[slot] = btb_update.is_return;
    end
    // A full stack drops its oldest address
    if (ras_push) begin
      if (ras_q.size() == `FETCH_RAS_DEPTH) begin
        void'(ras_q.pop_front());
      end
      ras_q.push_back(ras_push_addr);
    end
  endtask

  // Mid-cycle sampling sees settled registers and inputs
  always @(negedge clk) begin
    if (!rst_n) begin
      reset_model();
    end else begin
      if (cycle > 0 && prev_stall && !prev_flush && id_bundle !== prev_bundle) begin
        n_hold_err++;
        report_mismatch("bundle changed while decode was stalled");
      end
      if (cycle < 2 && id_bundle.valid) begin
        n_valid_err++;
        report_mismatch($sformatf("valid bundle %0d cycles after reset", cycle));
      end
      if (cycle == 2 && !id_bundle.valid) begin
        n_valid_err++;
        report_mismatch("no valid bundle two cycles after reset");
      end
      if (id_bundle.valid && !id_stall) begin
        check_bundle();
      end
      take_inputs();
      prev_bundle = id_bundle;
      prev_stall  = id_stall;
      prev_flush  = redirect.valid;
      cycle++;
    end
  end

endmodule

//--- dv/fetch_tb.sv
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_tb;
  import fetch_pkg::*;

  localparam logic [31:0] prog_pattern = 32'ha5c3_0000;
  localparam int          wait_limit   = 40;
  localparam int          n_rows       = 11;

  typedef enum logic [1:0] {
    sc_run,
    sc_stall,
    sc_redirect
  } scenario_e;

  // One scenario row; a stall length of 0 asks for a random length
  typedef struct packed {
    scenario_e   code;
    logic [31:0] start;
    logic [31:0] target;
    logic        btb_valid;
    logic [31:0] btb_pc;
    logic [31:0] btb_target;
    logic        btb_taken;
    logic        btb_return;
    logic        ras_valid;
    logic [31:0] ras_addr;
    logic [31:0] stall_len;
    logic [31:0] wait_pc;
  } row_t;

  logic                   clk;
  logic                   rst_n;
  logic                   id_stall;
  redirect_t              redirect;
  btb_update_t            btb_update;
  logic                   ras_push;
  logic [`FETCH_XLEN-1:0] ras_push_addr;
  logic                   load_en;
  logic [`FETCH_XLEN-1:0] load_addr;
  logic [31:0]            load_data;
  fetch_bundle_t          id_bundle;

  int     n_bundles;
  int     n_pc_err;
  int     n_data_err;
  int     n_pred_err;
  int     n_hold_err;
  int     n_valid_err;
  row_t   rows [n_rows];
  integer seed;
  logic   timed_out;

  fetch_unit i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .id_stall      (id_stall),
    .redirect      (redirect),
    .btb_update    (btb_update),
    .ras_push      (ras_push),
    .ras_push_addr (ras_push_addr),
    .load_en       (load_en),
    .load_addr     (load_addr),
    .load_data     (load_data),
    .id_bundle     (id_bundle)
  );

  fetch_checker #(
    .prog_pattern (prog_pattern)
  ) i_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .id_stall      (id_stall),
    .redirect      (redirect),
    .btb_update    (btb_update),
    .ras_push      (ras_push),
    .ras_push_addr (ras_push_addr),
    .id_bundle     (id_bundle),
    .n_bundles     (n_bundles),
    .n_pc_err      (n_pc_err),
    .n_data_err    (n_data_err),
    .n_pred_err    (n_pred_err),
    .n_hold_err    (n_hold_err),
    .n_valid_err   (n_valid_err)
  );

  always #4 clk = ~clk;

  // Inputs change 1 ns after the rising edge
  task automatic step_edge();
    @(posedge clk);
    #1;
  endtask

  // Wait for an accepted bundle, for any PC or for one PC
  task automatic wait_for_bundle(input logic any_pc, input logic [31:0] pc_want,
                                 input string what);
    int   n;
    logic found;
    n     = 0;
    found = 1'b0;
    while (!found && n < wait_limit) begin
      @(negedge clk);
      n++;
      if (id_bundle.valid && !id_stall && (any_pc || id_bundle.pc == pc_want)) begin
        found = 1'b1;
      end
    end
    if (!found) begin
      timed_out = 1'b1;
      $display("Timeout: %s saw no bundle for pc %h within %0d cycles", what, pc_want,
               wait_limit);
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < `FETCH_IMEM_WORDS; i++) begin
      step_edge();
      load_en   = 1'b1;
      load_addr = 32'(i) << 2;
      load_data = (32'(i) << 2) ^ prog_pattern;
    end
    step_edge();
    load_en = 1'b0;
  endtask

  // Training and pushes only ride on redirects, so later bundles see them at lookup
  task automatic fill_table();
    rows[0]  = '{sc_run, 32'd4, 32'h0, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 32'h0,
                 32'd0, 32'h0};
    rows[1]  = '{sc_stall, 32'd2, 32'h0, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 32'h0,
                 32'd3, 32'h0};
    rows[2]  = '{sc_stall, 32'd3, 32'h0, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 32'h0,
                 32'd0, 32'h0};
    rows[3]  = '{sc_redirect, 32'd2, 32'h100, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 32'h0,
                 32'd0, 32'h100};
    // Taken branch at 0x210 jumps back to 0x080
    rows[4]  = '{sc_redirect, 32'd3, 32'h200, 1'b1, 32'h210, 32'h080, 1'b1, 1'b0, 1'b0,
                 32'h0, 32'd0, 32'h080};
    rows[5]  = '{sc_stall, 32'd1, 32'h0, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 32'h0,
                 32'd0, 32'h0};
    // Return at 0x30c follows the pushed call address
    rows[6]  = '{sc_redirect, 32'd2, 32'h300, 1'b1, 32'h30c, 32'h1f0, 1'b1, 1'b1, 1'b1,
                 32'h044, 32'd0, 32'h044};
    rows[7]  = '{sc_redirect, 32'd2, 32'h2f8, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b1,
                 32'h120, 32'd0, 32'h120};
    // With the stack empty the return falls back to the BTB target
    rows[8]  = '{sc_redirect, 32'd2, 32'h304, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 32'h0,
                 32'd0, 32'h1f0};
    rows[9]  = '{sc_stall, 32'd4, 32'h0, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 32'h0,
                 32'd2, 32'h0};
    rows[10] = '{sc_run, 32'd6, 32'h0, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 32'h0,
                 32'd0, 32'h0};
  endtask

  task automatic apply_row(input row_t row);
    int len;
    step_edge();
    repeat (row.start) step_edge();
    case (row.code)
      sc_stall: begin
        len = row.stall_len;
        if (len == 0) begin
          len = 1 + int'({$random(seed)} % 32'd6);
        end
        id_stall = 1'b1;
        repeat (len) step_edge();
        id_stall = 1'b0;
        wait_for_bundle(1'b1, 32'h0, "bundle after stall");
      end
      sc_redirect: begin
        redirect.valid       = 1'b1;
        redirect.target      = row.target;
        btb_update.valid     = row.btb_valid;
        btb_update.pc        = row.btb_pc;
        btb_update.target    = row.btb_target;
        btb_update.taken     = row.btb_taken;
        btb_update.is_return = row.btb_return;
        ras_push             = row.ras_valid;
        ras_push_addr        = row.ras_addr;
        step_edge();
        redirect      = '0;
        btb_update    = '0;
        ras_push      = 1'b0;
        ras_push_addr = '0;
        wait_for_bundle(1'b0, row.wait_pc, "redirect row");
      end
      default: begin
        wait_for_bundle(1'b1, 32'h0, "run row");
      end
    endcase
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    id_stall      = 1'b0;
    redirect      = '0;
    btb_update    = '0;
    ras_push      = 1'b0;
    ras_push_addr = '0;
    load_en       = 1'b0;
    load_addr     = '0;
    load_data     = '0;
    seed          = 32'h83c5;
    timed_out     = 1'b0;
    fill_table();

    // Reset stays low through the load and for five cycles after it
    load_program();
    repeat (5) step_edge();
    rst_n = 1'b1;

    wait_for_bundle(1'b0, `FETCH_RESET_PC, "first fetch after reset");
    for (int r = 0; r < n_rows && !timed_out; r++) begin
      apply_row(rows[r]);
    end
    repeat (2) step_edge();

    $display("Checked %0d bundles; errors pc %0d data %0d prediction %0d hold %0d startup %0d",
             n_bundles, n_pc_err, n_data_err, n_pred_err, n_hold_err, n_valid_err);
    if (timed_out || n_bundles == 0 ||
        (n_pc_err + n_data_err + n_pred_err + n_hold_err + n_valid_err) != 0) begin
      $display("Result: FAILED");
    end else begin
      $display("Result: PASSED");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+src
src/fetch_pkg.sv
src/pc_gen.sv
src/branch_target_buffer.sv
src/return_address_stack.sv
src/imem_bram.sv
src/fetch_stage_bram.sv
src/fetch_unit.sv
dv/fetch_checker.sv
dv/fetch_tb.sv

//--- run.sh
#!/bin/sh
# Build the fetch testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module fetch_tb -f files.f -Mdir obj_dir -o fetch_sim

sim_status=0
./obj_dir/fetch_sim > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if [ "$sim_status" -ne 0 ] || ! grep -q "Result: PASSED" sim.log; then
  echo "Simulation ended without a passing result"
  exit 1
fi
echo "Simulation passed"
